/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP      = sdram_ctrl_tb
FILELIST = sim.f
BUILD    = obj_dir
LOG      = sim.log
RUNFLAGS = +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, then check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "No errors" $(LOG); then echo "TEST FAILED, run incomplete"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf $(BUILD) $(LOG)

/* bench/sdram_ctrl_chk.sv */
// SDRAM pin protocol assertions
`default_nettype none

module sdram_ctrl_chk (
    input logic           clock,
    input logic           reset,
    input logic           ready,
    input logic           dram_cs_n,
    input logic           dram_ras_n,
    input logic           dram_cas_n,
    input logic           dram_we_n,
    input sdram_pkg::ba_t dram_ba
);
    timeunit 1ns;
    timeprecision 100ps;
    import sdram_pkg::*;

    cmd_t pin_cmd;
    int   assert_errors = 0;

    assign pin_cmd = {dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n};

    bank_zero: assert property (@(posedge clock) disable iff (reset) dram_ba == ba_t'(0))
    else
    begin
        $error("dram_ba left bank 0");
        assert_errors++;
    end

    ready_sticky: assert property (@(posedge clock) disable iff (reset) ready |=> ready)
    else
    begin
        $error("ready fell after rising");
        assert_errors++;
    end

    // Only the refresh source owns the bus after init
    nop_or_ref: assert property (@(posedge clock) disable iff (reset)
                                 ready |-> (pin_cmd == cmd_nop || pin_cmd == cmd_ref))
    else
    begin
        $error("Command other than NOP or REF after ready");
        assert_errors++;
    end

endmodule

`default_nettype wire

/* bench/sdram_ctrl_monitor.sv */
// SDRAM pin command checker
`default_nettype none

module sdram_ctrl_monitor (
    input  logic             clock,
    input  logic             reset,
    input  logic             enable,
    input  logic             ready,
    input  logic             dram_cs_n,
    input  logic             dram_ras_n,
    input  logic             dram_cas_n,
    input  logic             dram_we_n,
    input  sdram_pkg::addr_t dram_addr,
    input  sdram_pkg::ba_t   dram_ba,
    output logic             done,
    output int               check_count,
    output int               error_count
);
    timeunit 1ns;
    timeprecision 100ps;
    import sdram_pkg::*;

    // Pin offsets, counted in cycles from the edge that raises enable
    localparam int pre_at   = power_up_cycles + 2;  // Init state plus pin register
    localparam int ref_at   = pre_at + 1 + trp_cycles;
    localparam int mrs_at   = ref_at + init_refresh_count * trc_cycles;
    localparam int ready_at = mrs_at + tmrd_cycles;  // Done pulse on last mrd_wait cycle
    localparam int prd_at   = ready_at + refresh_interval + 1;  // First periodic REF
    localparam int end_at   = prd_at + 4 * refresh_interval;

    cmd_t  pin_cmd;
    cmd_t  exp_cmd;
    addr_t exp_addr;
    logic  exp_ready;
    logic  started = 1'b0;
    logic  finished = 1'b0;
    int    offset = 0;
    int    idle_cycles = 0;  // Since reset release
    int    test = 1;
    int    test_errors = 0;
    int    test_refs = 0;
    int    checks = 0;
    int    errors = 0;

    assign pin_cmd     = {dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n};
    assign done        = finished;
    assign check_count = checks;
    assign error_count = errors;

    function automatic void expected_pins(input int n, output cmd_t cmd, output addr_t addr,
                                          output logic rdy);
        cmd  = cmd_nop;
        addr = '0;
        rdy  = (n >= ready_at);
        if (n == pre_at)
        begin
            cmd  = cmd_pre;
            addr = addr_all_banks;
        end
        else if (n >= ref_at && n < mrs_at && (n - ref_at) % trc_cycles == 0)
            cmd = cmd_ref;
        else if (n == mrs_at)
        begin
            cmd  = cmd_mrs;
            addr = mode_word;
        end
        else if (n >= prd_at && (n - prd_at) % refresh_interval == 0)
            cmd = cmd_ref;
    endfunction

    function automatic int test_of(input logic run, input int n);
        if (!run)
            return 1;  // Reset and idle
        if (n < ref_at)
            return 2;  // Power-up wait and PRECHARGE ALL
        if (n < mrs_at)
            return 3;  // Init refreshes
        if (n < prd_at)
            return 4;  // MRS and ready
        return 5;  // Periodic refresh
    endfunction

    function automatic int refs_due(input int id);
        case (id)
            3:       return init_refresh_count;
            5:       return 4;
            default: return 0;
        endcase
    endfunction

    task automatic close_test();
        if (test_refs != refs_due(test))
        begin
            $display("Test %0d saw %0d REF commands, %0d were due", test, test_refs,
                     refs_due(test));
            test_errors++;
            errors++;
        end
        $display("Test %0d %s, %0d mismatches", test, (test_errors == 0) ? "pass" : "fail",
                 test_errors);
        test_errors = 0;
        test_refs   = 0;
    endtask

    // Sample on the falling edge, pins settled since the rising one
    always @(negedge clock)
    begin
        if (!finished)
        begin
            if (!reset && !started && enable)
                started = 1'b1;
            if (started)
                expected_pins(offset, exp_cmd, exp_addr, exp_ready);
            else
            begin
                exp_cmd   = (idle_cycles == 0) ? cmd_inhibit : cmd_nop;  // Reset value first
                exp_addr  = '0;
                exp_ready = 1'b0;
            end
            if (test_of(started, offset) != test)
            begin
                close_test();
                test = test_of(started, offset);
            end
            checks++;
            if (pin_cmd == cmd_ref)
                test_refs++;
            if (pin_cmd !== exp_cmd || dram_addr !== exp_addr || ready !== exp_ready ||
                dram_ba !== '0)
            begin
                $display("ERR %0t: test %0d offset %0d got cmd %b addr %h ba %0d ready %b,",
                         $time, test, offset, pin_cmd, dram_addr, dram_ba, ready,
                         " expected cmd %b addr %h ba 0 ready %b", exp_cmd, exp_addr, exp_ready);
                test_errors++;
                errors++;
            end
            if (started)
                offset++;
            else if (!reset)
                idle_cycles++;
            if (offset == end_at)
            begin
                close_test();
                finished = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* bench/sdram_ctrl_tb.sv */
// SDRAM controller testbench
`default_nettype none

module sdram_ctrl_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import sdram_pkg::*;

    // Reset, longest enable delay, init, then four refresh periods
    localparam int run_cycles = 2 + 18 + power_up_cycles + init_refresh_count * trc_cycles
                                + 40 + 4 * refresh_interval;
    localparam int margin_cycles = 50;

    logic        clock = 1'b0;
    logic        reset = 1'b1;
    logic        enable = 1'b0;
    logic        ready;
    logic        dram_cs_n;
    logic        dram_ras_n;
    logic        dram_cas_n;
    logic        dram_we_n;
    addr_t       dram_addr;
    ba_t         dram_ba;
    logic        checks_done;
    int          check_count;
    int          error_count;
    int          assert_count;
    int          enable_delay;
    logic [31:0] rand_state = 32'h2804;

    always #5 clock = ~clock;

    sdram_ctrl sdram_ctrl_i (
        .clock      (clock),
        .reset      (reset),
        .enable     (enable),
        .ready      (ready),
        .dram_cs_n  (dram_cs_n),
        .dram_ras_n (dram_ras_n),
        .dram_cas_n (dram_cas_n),
        .dram_we_n  (dram_we_n),
        .dram_addr  (dram_addr),
        .dram_ba    (dram_ba)
    );

    sdram_ctrl_monitor monitor_i (
        .clock       (clock),
        .reset       (reset),
        .enable      (enable),
        .ready       (ready),
        .dram_cs_n   (dram_cs_n),
        .dram_ras_n  (dram_ras_n),
        .dram_cas_n  (dram_cas_n),
        .dram_we_n   (dram_we_n),
        .dram_addr   (dram_addr),
        .dram_ba     (dram_ba),
        .done        (checks_done),
        .check_count (check_count),
        .error_count (error_count)
    );

    bind sdram_ctrl sdram_ctrl_chk chk_i (
        .clock      (clock),
        .reset      (reset),
        .ready      (ready),
        .dram_cs_n  (dram_cs_n),
        .dram_ras_n (dram_ras_n),
        .dram_cas_n (dram_cas_n),
        .dram_we_n  (dram_we_n),
        .dram_ba    (dram_ba)
    );

    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    initial
    begin
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        rand_state = next_random(rand_state);
        enable_delay = 3 + int'((rand_state >> 16) % 32'd16);  // 3 to 18 idle cycles
        repeat (enable_delay) @(posedge clock);
        enable <= 1'b1;  // Level, stays high
        wait (checks_done);
        assert_count = sdram_ctrl_i.chk_i.assert_errors;
        $display("Checks %0d, mismatches %0d, assertion failures %0d", check_count,
                 error_count, assert_count);
        if (error_count == 0 && assert_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    // Watchdog
    initial
    begin
        repeat (run_cycles + margin_cycles) @(posedge clock);
        $display("Run timed out after %0d cycles before all tests finished",
                 run_cycles + margin_cycles);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/sdram_cmd_out.sv */
// SDRAM pin register stage
`default_nettype none

module sdram_cmd_out (
    input  logic             clock,
    input  logic             reset,
    input  sdram_pkg::cmd_t  init_cmd,
    input  sdram_pkg::addr_t init_addr,
    input  logic             init_done,
    input  logic             ref_strobe,
    output logic             ready,       // High once init has finished
    output logic             dram_cs_n,
    output logic             dram_ras_n,
    output logic             dram_cas_n,
    output logic             dram_we_n,
    output sdram_pkg::addr_t dram_addr,
    output sdram_pkg::ba_t   dram_ba
);
    import sdram_pkg::*;

    cmd_t  cmd_q;      // Registered pin command
    cmd_t  next_cmd;
    addr_t next_addr;

    // Init sequencer owns the bus until ready, refresh after
    always_comb
    begin
        if (ready)
        begin
            next_cmd  = ref_strobe ? cmd_ref : cmd_nop;
            next_addr = '0;
        end
        else
        begin
            next_cmd  = init_cmd;
            next_addr = init_addr;
        end
    end

    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
        begin
            ready     <= 1'b0;
            cmd_q     <= cmd_inhibit;  // Chip deselected out of reset
            dram_addr <= '0;
        end
        else
        begin
            if (init_done)
                ready <= 1'b1;  // Sticky until next reset
            cmd_q     <= next_cmd;
            dram_addr <= next_addr;
        end
    end

    assign {dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n} = cmd_q;
    assign dram_ba = ba_t'(0);  // Bank 0, unused by PALL, REF and MRS

endmodule

`default_nettype wire

/* rtl/sdram_ctrl.sv */
// SDRAM init and refresh controller top
`default_nettype none

module sdram_ctrl (
    input  logic             clock,
    input  logic             reset,
    input  logic             enable,      // Starts initialization
    output logic             ready,
    output logic             dram_cs_n,
    output logic             dram_ras_n,
    output logic             dram_cas_n,
    output logic             dram_we_n,
    output sdram_pkg::addr_t dram_addr,
    output sdram_pkg::ba_t   dram_ba
);
    import sdram_pkg::*;

    cmd_t  init_cmd;    // Raw sequencer command
    addr_t init_addr;
    logic  init_done;   // End of MRS wait
    logic  ref_strobe;  // Periodic refresh request

    sdram_init init_i (
        .clock     (clock),
        .reset     (reset),
        .enable    (enable),
        .init_cmd  (init_cmd),
        .init_addr (init_addr),
        .init_done (init_done)
    );

    sdram_refresh refresh_i (
        .clock      (clock),
        .reset      (reset),
        .init_done  (init_done),
        .ref_strobe (ref_strobe)
    );

    sdram_cmd_out cmd_out_i (
        .clock      (clock),
        .reset      (reset),
        .init_cmd   (init_cmd),
        .init_addr  (init_addr),
        .init_done  (init_done),
        .ref_strobe (ref_strobe),
        .ready      (ready),
        .dram_cs_n  (dram_cs_n),
        .dram_ras_n (dram_ras_n),
        .dram_cas_n (dram_cas_n),
        .dram_we_n  (dram_we_n),
        .dram_addr  (dram_addr),
        .dram_ba    (dram_ba)
    );

endmodule

`default_nettype wire

/* rtl/sdram_init.sv */
// SDRAM power-up sequencer
`default_nettype none

module sdram_init (
    input  logic             clock,
    input  logic             reset,
    input  logic             enable,     // Level that starts the sequence
    output sdram_pkg::cmd_t  init_cmd,
    output sdram_pkg::addr_t init_addr,
    output logic             init_done   // One-cycle pulse at the end
);
    import sdram_pkg::*;

    init_state_t state;
    init_state_t next_state;
    count_t      long_count;   // Power-up wait, then REF tally
    short_t      short_count;  // trp, trc and tmrd spacing
    logic        long_clear;
    logic        long_enable;
    logic        short_clear;
    logic        short_enable;
    logic        power_up_end;
    logic        trp_end;
    logic        trc_end;
    logic        tmrd_end;
    logic        refs_done;

    sync_parallel_counter #(.size(count_width), .init_value(0)) long_counter (
        .clock  (clock),
        .reset  (reset),
        .clear  (long_clear),
        .enable (long_enable),
        .value  (long_count)
    );

    sync_parallel_counter #(.size(short_width), .init_value(0)) short_counter (
        .clock  (clock),
        .reset  (reset),
        .clear  (short_clear),
        .enable (short_enable),
        .value  (short_count)
    );

    assign power_up_end = (long_count == count_t'(power_up_cycles - 1));
    assign trp_end      = (short_count == short_t'(trp_cycles - 1));
    assign trc_end      = (short_count == short_t'(trc_cycles - 2));  // REF cycle is the first
    assign tmrd_end     = (short_count == short_t'(tmrd_cycles - 1));
    assign refs_done    = (long_count == count_t'(init_refresh_count));

    assign long_clear   = (state == idle) || (state == pall);  // Reused as REF tally after PALL
    assign long_enable  = (state == power_up) || (state == auto_ref);
    assign short_clear  = (state == pall) || (state == auto_ref) || (state == mode_reg);
    // Parks one past tmrd so the done pulse never repeats
    assign short_enable = !((state == mrd_wait) && (short_count == short_t'(tmrd_cycles)));
    assign init_done    = (state == mrd_wait) && tmrd_end;

    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
            state <= idle;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            idle:      if (enable) next_state = power_up;
            power_up:  if (power_up_end) next_state = pall;
            pall:      next_state = pall_wait;
            pall_wait: if (trp_end) next_state = auto_ref;
            auto_ref:  next_state = ref_wait;
            ref_wait:
            begin
                if (trc_end)
                    next_state = refs_done ? mode_reg : auto_ref;  // Last trc still honored
            end
            mode_reg:  next_state = mrd_wait;
            mrd_wait:  next_state = mrd_wait;  // Terminal state so init runs once per reset
            default:   next_state = idle;
        endcase
    end

    // Moore outputs
    always_comb
    begin
        init_cmd  = cmd_nop;
        init_addr = '0;  // Don't care outside PALL and MRS
        case (state)
            pall:
            begin
                init_cmd  = cmd_pre;
                init_addr = addr_all_banks;
            end
            auto_ref: init_cmd = cmd_ref;
            mode_reg:
            begin
                init_cmd  = cmd_mrs;
                init_addr = mode_word;
            end
            default:  init_cmd = cmd_nop;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/sdram_pkg.sv */
// SDRAM controller shared definitions
`default_nettype none

package sdram_pkg;

    // Pin-level vectors
    typedef logic [3:0]  cmd_t;   // cs_n, ras_n, cas_n, we_n
    typedef logic [12:0] addr_t;  // Row or mode register address
    typedef logic [1:0]  ba_t;    // Bank select

    // Command encodings as seen on the pins
    localparam cmd_t cmd_nop     = 4'b0111;
    localparam cmd_t cmd_pre     = 4'b0010;  // PRECHARGE
    localparam cmd_t cmd_ref     = 4'b0001;  // AUTO REFRESH
    localparam cmd_t cmd_mrs     = 4'b0000;  // MODE REGISTER SET
    localparam cmd_t cmd_inhibit = 4'b1111;  // DESELECT, chip not selected

    localparam addr_t addr_all_banks = 13'h0400;  // A10 high, all banks
    localparam addr_t mode_word      = 13'h0230;  // Single write, CL3, sequential, BL1

    // Delays in clock cycles, shortened for simulation
    localparam int power_up_cycles    = 20;  // Stabilization wait
    localparam int trp_cycles         = 2;   // PRECHARGE to REF
    localparam int trc_cycles         = 9;   // REF to REF
    localparam int init_refresh_count = 8;
    localparam int tmrd_cycles        = 2;   // MRS to first command
    localparam int refresh_interval   = 40;  // Periodic REF spacing

    localparam int count_width = 8;  // Long waits and refresh interval
    localparam int short_width = 4;  // trp, trc and tmrd spacing

    typedef logic [count_width-1:0] count_t;
    typedef logic [short_width-1:0] short_t;

    typedef enum logic [2:0] {
        idle, power_up, pall, pall_wait, auto_ref, ref_wait, mode_reg, mrd_wait
    } init_state_t;

    typedef enum logic [1:0] {
        off, counting, issue
    } refresh_state_t;

endpackage

`default_nettype wire

/* rtl/sdram_refresh.sv */
// Periodic auto-refresh request generator
`default_nettype none

module sdram_refresh (
    input  logic clock,
    input  logic reset,
    input  logic init_done,   // Starts the interval timer
    output logic ref_strobe   // One cycle per refresh period
);
    import sdram_pkg::*;

    refresh_state_t state;
    refresh_state_t next_state;
    count_t         interval_count;
    logic           interval_end;
    logic           count_clear;

    // Free-running, the issue cycle counts toward the next period
    sync_parallel_counter #(.size(count_width), .init_value(0)) interval_counter (
        .clock  (clock),
        .reset  (reset),
        .clear  (count_clear),
        .enable (1'b1),
        .value  (interval_count)
    );

    assign interval_end = (state == counting) &&
                          (interval_count == count_t'(refresh_interval - 1));
    assign count_clear  = (state == off) || interval_end;  // Held at zero until init ends

    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
            state <= off;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            off:
            begin
                if (init_done)
                    next_state = counting;
            end
            counting:
            begin
                if (interval_end)
                    next_state = issue;
            end
            issue:   next_state = counting;  // Never returns to off
            default: next_state = off;
        endcase
    end

    assign ref_strobe = (state == issue);

endmodule

`default_nettype wire

/* rtl/sync_parallel_counter.sv */
// Parallel up counter
`default_nettype none

module sync_parallel_counter #(
    parameter int              size       = 4,
    parameter logic [size-1:0] init_value = '0
) (
    input  logic            clock,
    input  logic            reset,
    input  logic            clear,   // Synchronous reload
    input  logic            enable,  // Count this cycle
    output logic [size-1:0] value
);

    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
            value <= init_value;
        else if (clear)
            value <= init_value;  // Clear wins over enable
        else if (enable)
            value <= value + 1'b1;  // Wraps at full scale
    end

endmodule

`default_nettype wire

/* sim.f */
rtl/sdram_pkg.sv
rtl/sync_parallel_counter.sv
rtl/sdram_init.sv
rtl/sdram_refresh.sv
rtl/sdram_cmd_out.sv
rtl/sdram_ctrl.sv
bench/sdram_ctrl_chk.sv
bench/sdram_ctrl_monitor.sv
bench/sdram_ctrl_tb.sv
